/* common/vga_pkg.sv */
//--------------------------------------------------------------------------
// VGA display types and default 640x480 timing values
//--------------------------------------------------------------------------

package vga_pkg;

    //----------------------------------------------------------------------
    // Types
    //----------------------------------------------------------------------

    // Screen coordinate, wide enough for the full 800x525 raster
    typedef logic [9:0] coord_t;

    //----------------------------------------------------------------------
    // Horizontal timing in pixels
    //----------------------------------------------------------------------

    localparam int H_VISIBLE = 640;     // Active pixels per line
    localparam int H_FRONT   = 16;      // Front porch
    localparam int H_SYNC    = 96;      // Sync pulse width
    localparam int H_BACK    = 48;      // Back porch

    //----------------------------------------------------------------------
    // Vertical timing in lines
    //----------------------------------------------------------------------

    localparam int V_VISIBLE = 480;     // Active lines per frame
    localparam int V_FRONT   = 10;      // Front porch
    localparam int V_SYNC    = 2;       // Sync pulse width
    localparam int V_BACK    = 33;      // Back porch

    // Totals come out at 800 x 525 at these defaults
    // and must stay below 1024 to fit coord_t

endpackage

/* common/game_pkg.sv */
//--------------------------------------------------------------------------
// Frog game types, arrow keycodes, sizes and playfield colours
//--------------------------------------------------------------------------

package game_pkg;

    //----------------------------------------------------------------------
    // Types
    //----------------------------------------------------------------------

    typedef logic [7:0] keycode_t;      // USB HID keycode
    typedef logic [7:0] color_t;        // One colour channel
    typedef logic [6:0] seg_t;          // Segments gfedcba, active low
    typedef logic [3:0] dir_t;          // {left, up, down, right}

    // Arrow keys from the HID usage table
    localparam keycode_t KEY_RIGHT = 8'h4f;
    localparam keycode_t KEY_LEFT  = 8'h50;
    localparam keycode_t KEY_DOWN  = 8'h51;
    localparam keycode_t KEY_UP    = 8'h52;

    // Frog box and hop distance in pixels
    localparam int FROG_SIZE = 8;
    localparam int FROG_STEP = 8;

    //----------------------------------------------------------------------
    // Colours
    //----------------------------------------------------------------------

    localparam color_t GRASS_R = 8'h20;     // Top and bottom strips
    localparam color_t GRASS_G = 8'hb0;
    localparam color_t GRASS_B = 8'h30;
    localparam color_t WATER_R = 8'h10;     // Upper half
    localparam color_t WATER_G = 8'h40;
    localparam color_t WATER_B = 8'hd0;
    localparam color_t ROAD_R  = 8'h50;     // Lower half
    localparam color_t ROAD_G  = 8'h50;
    localparam color_t ROAD_B  = 8'h50;
    localparam color_t FROG_R  = 8'hf0;     // Bright yellow frog
    localparam color_t FROG_G  = 8'he0;
    localparam color_t FROG_B  = 8'h10;

endpackage

/* verilog/key_decoder.sv */
//--------------------------------------------------------------------------
// Keycode decode of the arrow keys, last arrow held on the LEDs,
// and both keycode nibbles shown on seven-segment digits
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module key_decoder
(
    input  logic               Clk,
    input  logic               reset,
    input  game_pkg::keycode_t keycode,
    output game_pkg::dir_t     dir,
    output game_pkg::dir_t     leds,
    output game_pkg::seg_t     hex0,
    output game_pkg::seg_t     hex1
);

    game_pkg::dir_t arrow;      // One-hot arrow match or zero

    // Nibble to active-low segments, gfedcba
    function automatic game_pkg::seg_t hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: hex_seg = 7'h40;
            4'h1: hex_seg = 7'h79;
            4'h2: hex_seg = 7'h24;
            4'h3: hex_seg = 7'h30;
            4'h4: hex_seg = 7'h19;
            4'h5: hex_seg = 7'h12;
            4'h6: hex_seg = 7'h02;
            4'h7: hex_seg = 7'h78;
            4'h8: hex_seg = 7'h00;
            4'h9: hex_seg = 7'h10;
            4'ha: hex_seg = 7'h08;
            4'hb: hex_seg = 7'h03;     // Lower case b
            4'hc: hex_seg = 7'h46;
            4'hd: hex_seg = 7'h21;     // Lower case d
            4'he: hex_seg = 7'h06;
            default: hex_seg = 7'h0e;  // F
        endcase
    endfunction

    // Bit order matches the LED row
    assign arrow = {keycode == game_pkg::KEY_LEFT,
                    keycode == game_pkg::KEY_UP,
                    keycode == game_pkg::KEY_DOWN,
                    keycode == game_pkg::KEY_RIGHT};

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            dir  <= '0;
            leds <= '0;
            hex0 <= 7'h7f;          // Digits dark
            hex1 <= 7'h7f;
        end
        else
        begin
            dir  <= arrow;
            if (arrow != '0)
                leds <= arrow;      // Hold last arrow
            hex0 <= hex_seg(keycode[3:0]);
            hex1 <= hex_seg(keycode[7:4]);
        end
    end

endmodule

/* frog/frog_motion.sv */
//--------------------------------------------------------------------------
// Frog position, one clamped hop per key press, stepped at frame start
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module frog_motion
#(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
)
(
    input  logic             Clk,
    input  logic             reset,
    input  logic             frame_start,
    input  game_pkg::dir_t   dir,
    output vga_pkg::coord_t  frog_x,
    output vga_pkg::coord_t  frog_y
);

    // Furthest top-left corner that keeps the box on screen
    localparam vga_pkg::coord_t X_MAX = vga_pkg::coord_t'(H_VISIBLE - game_pkg::FROG_SIZE);
    localparam vga_pkg::coord_t Y_MAX = vga_pkg::coord_t'(V_VISIBLE - game_pkg::FROG_SIZE);
    localparam vga_pkg::coord_t STEP  = vga_pkg::coord_t'(game_pkg::FROG_STEP);

    // Start position, bottom centre
    localparam vga_pkg::coord_t X_HOME = vga_pkg::coord_t'(X_MAX / 2);
    localparam vga_pkg::coord_t Y_HOME = Y_MAX;

    typedef enum logic [0:0]
    {
        HOP_IDLE,   // Waiting for a key
        HOP_WAIT    // Key still held, no further hops
    } frog_state_t;

    frog_state_t     state;
    vga_pkg::coord_t x_next;
    vga_pkg::coord_t y_next;

    //----------------------------------------------------------------------
    // Next position with clamping
    //----------------------------------------------------------------------

    always_comb
    begin
        x_next = frog_x;
        y_next = frog_y;
        if (dir[0])                                 // Right
            x_next = (frog_x > X_MAX - STEP) ? X_MAX : frog_x + STEP;
        else if (dir[3])                            // Left
            x_next = (frog_x < STEP) ? '0 : frog_x - STEP;
        else if (dir[1])                            // Down
            y_next = (frog_y > Y_MAX - STEP) ? Y_MAX : frog_y + STEP;
        else if (dir[2])                            // Up
            y_next = (frog_y < STEP) ? '0 : frog_y - STEP;
    end

    //----------------------------------------------------------------------
    // Hop FSM, evaluated once per frame
    //----------------------------------------------------------------------

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            state  <= HOP_IDLE;
            frog_x <= X_HOME;
            frog_y <= Y_HOME;
        end
        else if (frame_start)
        begin
            case (state)
                HOP_IDLE:
                begin
                    if (dir != '0)
                    begin
                        frog_x <= x_next;
                        frog_y <= y_next;
                        state  <= HOP_WAIT;
                    end
                end
                HOP_WAIT:
                begin
                    if (dir == '0)
                        state <= HOP_IDLE;  // Key released
                end
                default:
                    state <= HOP_IDLE;
            endcase
        end
    end

endmodule

/* verilog/vga_timing.sv */
//--------------------------------------------------------------------------
// VGA raster counters with half-rate pixel enable, syncs, blanking
// and a one-cycle pulse at the start of vertical blanking
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module vga_timing
#(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
)
(
    input  logic            Clk,
    input  logic            reset,
    output logic            pixel_en,
    output vga_pkg::coord_t draw_x,
    output vga_pkg::coord_t draw_y,
    output logic            hs,
    output logic            vs,
    output logic            blank_n,
    output logic            frame_start
);

    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START  = H_VISIBLE + H_FRONT;
    localparam int VS_START  = V_VISIBLE + V_FRONT;

    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;
    logic            line_end;

    assign line_end = (h_cnt == vga_pkg::coord_t'(H_TOTAL - 1));

    //----------------------------------------------------------------------
    // Pixel enable and raster counters
    //----------------------------------------------------------------------

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            pixel_en    <= 1'b0;
            h_cnt       <= '0;
            v_cnt       <= '0;
            hs          <= 1'b1;    // Syncs idle high
            vs          <= 1'b1;
            blank_n     <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            pixel_en <= ~pixel_en;  // Every second Clk
            // Pulse lines up with draw_y entering V_VISIBLE at x 0
            frame_start <= pixel_en && h_cnt == '0 &&
                           v_cnt == vga_pkg::coord_t'(V_VISIBLE);
            if (pixel_en)
            begin
                h_cnt <= line_end ? '0 : h_cnt + 1'b1;
                if (line_end)
                    v_cnt <= (v_cnt == vga_pkg::coord_t'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
                hs      <= !(h_cnt >= HS_START && h_cnt < HS_START + H_SYNC);
                vs      <= !(v_cnt >= VS_START && v_cnt < VS_START + V_SYNC);
                blank_n <= (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
            end
        end
    end

    // Raster position, same timing as the syncs
    always_ff @(posedge Clk)
    begin
        if (pixel_en)
        begin
            draw_x <= h_cnt;
            draw_y <= v_cnt;
        end
    end

endmodule

/* verilog/color_mapper.sv */
//--------------------------------------------------------------------------
// Pixel colour from frog box and background bands, registered
// together with sync and blank so all leave aligned
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module color_mapper
#(
    parameter int V_VISIBLE = 480
)
(
    input  logic             Clk,
    input  logic             reset,
    input  logic             pixel_en,
    input  vga_pkg::coord_t  draw_x,
    input  vga_pkg::coord_t  draw_y,
    input  logic             blank_in_n,
    input  logic             hs_in,
    input  logic             vs_in,
    input  vga_pkg::coord_t  frog_x,
    input  vga_pkg::coord_t  frog_y,
    output game_pkg::color_t vga_r,
    output game_pkg::color_t vga_g,
    output game_pkg::color_t vga_b,
    output logic             vga_hs,
    output logic             vga_vs,
    output logic             vga_blank_n
);

    localparam int GRASS_H = V_VISIBLE / 8;     // Strip height
    localparam vga_pkg::coord_t SIZE = vga_pkg::coord_t'(game_pkg::FROG_SIZE);

    logic             in_frog;
    game_pkg::color_t r_next, g_next, b_next;

    assign in_frog = draw_x >= frog_x && draw_x < frog_x + SIZE &&
                     draw_y >= frog_y && draw_y < frog_y + SIZE;

    always_comb
    begin
        if (in_frog)
            {r_next, g_next, b_next} = {game_pkg::FROG_R, game_pkg::FROG_G, game_pkg::FROG_B};
        else if (draw_y < GRASS_H || draw_y >= V_VISIBLE - GRASS_H)
            {r_next, g_next, b_next} = {game_pkg::GRASS_R, game_pkg::GRASS_G, game_pkg::GRASS_B};
        else if (draw_y < V_VISIBLE / 2)
            {r_next, g_next, b_next} = {game_pkg::WATER_R, game_pkg::WATER_G, game_pkg::WATER_B};
        else
            {r_next, g_next, b_next} = {game_pkg::ROAD_R, game_pkg::ROAD_G, game_pkg::ROAD_B};
    end

    // One pixel behind vga_timing
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            {vga_r, vga_g, vga_b} <= '0;
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end
        else if (pixel_en)
        begin
            {vga_r, vga_g, vga_b} <= blank_in_n ? {r_next, g_next, b_next} : '0;  // Black in blanking
            vga_hs      <= hs_in;
            vga_vs      <= vs_in;
            vga_blank_n <= blank_in_n;
        end
    end

endmodule

/* verilog/frogger_top.sv */
//--------------------------------------------------------------------------
// Frog game core, key decode, frog motion, VGA timing and colour
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module frogger_top
#(
    parameter int H_VISIBLE = vga_pkg::H_VISIBLE,
    parameter int H_FRONT   = vga_pkg::H_FRONT,
    parameter int H_SYNC    = vga_pkg::H_SYNC,
    parameter int H_BACK    = vga_pkg::H_BACK,
    parameter int V_VISIBLE = vga_pkg::V_VISIBLE,
    parameter int V_FRONT   = vga_pkg::V_FRONT,
    parameter int V_SYNC    = vga_pkg::V_SYNC,
    parameter int V_BACK    = vga_pkg::V_BACK
)
(
    input  logic               Clk,
    input  logic               reset,
    input  game_pkg::keycode_t keycode,     // Level from the USB host
    output game_pkg::seg_t     hex0,
    output game_pkg::seg_t     hex1,
    output game_pkg::dir_t     leds,
    output game_pkg::color_t   vga_r,
    output game_pkg::color_t   vga_g,
    output game_pkg::color_t   vga_b,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic               vga_blank_n,
    output logic               pixel_en
);

    game_pkg::dir_t  dir;
    vga_pkg::coord_t draw_x, draw_y;
    vga_pkg::coord_t frog_x, frog_y;
    logic            hs, vs, blank_n;
    logic            frame_start;

    // Decode
    key_decoder u_keys (.Clk, .reset, .keycode, .dir, .leds, .hex0, .hex1);

    // Execute, one hop per press
    frog_motion #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)) u_frog
    (
        .Clk, .reset, .frame_start, .dir, .frog_x, .frog_y
    );

    vga_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga
    (
        .Clk, .reset, .pixel_en, .draw_x, .draw_y, .hs, .vs, .blank_n, .frame_start
    );

    // Result, pixel colour
    color_mapper #(.V_VISIBLE(V_VISIBLE)) u_color
    (
        .Clk, .reset, .pixel_en, .draw_x, .draw_y,
        .blank_in_n(blank_n), .hs_in(hs), .vs_in(vs),
        .frog_x, .frog_y,
        .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs, .vga_blank_n
    );

endmodule

/* tb/tb_frogger_ref.svh */
//--------------------------------------------------------------------------
// Reference model functions for the frog game testbench
//--------------------------------------------------------------------------
`ifndef TB_FROGGER_REF_SVH
`define TB_FROGGER_REF_SVH

// Lit segments gfedcba for one hex digit, then inverted for active low
function automatic game_pkg::seg_t ref_seg(input logic [3:0] nib);
    logic [6:0] lit;
    case (nib)
        4'h0: lit = 7'h3f;
        4'h1: lit = 7'h06;
        4'h2: lit = 7'h5b;
        4'h3: lit = 7'h4f;
        4'h4: lit = 7'h66;
        4'h5: lit = 7'h6d;
        4'h6: lit = 7'h7d;
        4'h7: lit = 7'h07;
        4'h8: lit = 7'h7f;
        4'h9: lit = 7'h6f;
        4'ha: lit = 7'h77;
        4'hb: lit = 7'h7c;      // b
        4'hc: lit = 7'h39;
        4'hd: lit = 7'h5e;      // d
        4'he: lit = 7'h79;
        default: lit = 7'h71;
    endcase
    return ~lit;
endfunction

// Arrow key to direction bit, right down up left from bit 0
function automatic game_pkg::dir_t ref_dir(input game_pkg::keycode_t key);
    game_pkg::dir_t d;
    d = '0;
    if (key == game_pkg::KEY_RIGHT) d[0] = 1'b1;
    if (key == game_pkg::KEY_DOWN)  d[1] = 1'b1;
    if (key == game_pkg::KEY_UP)    d[2] = 1'b1;
    if (key == game_pkg::KEY_LEFT)  d[3] = 1'b1;
    return d;
endfunction

// Horizontal hop, clamped to 0..x_max
function automatic int step_x(input int x, input game_pkg::dir_t d, input int x_max);
    int nx;
    nx = x;
    if (d[0]) nx = x + game_pkg::FROG_STEP;
    if (d[3]) nx = x - game_pkg::FROG_STEP;
    if (nx > x_max) nx = x_max;
    if (nx < 0) nx = 0;
    return nx;
endfunction

// Vertical hop, down grows y
function automatic int step_y(input int y, input game_pkg::dir_t d, input int y_max);
    int ny;
    ny = y;
    if (d[1]) ny = y + game_pkg::FROG_STEP;
    if (d[2]) ny = y - game_pkg::FROG_STEP;
    if (ny > y_max) ny = y_max;
    if (ny < 0) ny = 0;
    return ny;
endfunction

// Visible pixel colour as {r, g, b}
function automatic logic [23:0] ref_color(input int x, input int y, input int fx, input int fy);
    int strip;
    strip = V_VISIBLE / 8;              // Grass eighth
    if (x >= fx && x < fx + game_pkg::FROG_SIZE && y >= fy && y < fy + game_pkg::FROG_SIZE)
        return {game_pkg::FROG_R, game_pkg::FROG_G, game_pkg::FROG_B};
    if (y < strip || y >= V_VISIBLE - strip)
        return {game_pkg::GRASS_R, game_pkg::GRASS_G, game_pkg::GRASS_B};
    if (y < V_VISIBLE / 2)
        return {game_pkg::WATER_R, game_pkg::WATER_G, game_pkg::WATER_B};
    return {game_pkg::ROAD_R, game_pkg::ROAD_G, game_pkg::ROAD_B};
endfunction

`endif

/* tb/tb_frogger.sv */
//--------------------------------------------------------------------------
// Testbench for the frog game core, keys, frog hops and VGA raster
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_frogger;

    // Small raster so a frame is short
    localparam int H_VISIBLE = 64;
    localparam int H_FRONT   = 4;
    localparam int H_SYNC    = 8;
    localparam int H_BACK    = 4;
    localparam int V_VISIBLE = 48;
    localparam int V_FRONT   = 2;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 3;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START  = H_VISIBLE + H_FRONT;
    localparam int VS_START  = V_VISIBLE + V_FRONT;
    localparam int FRAME_CLKS   = 2 * H_TOTAL * V_TOTAL;        // Two Clk per pixel
    localparam int TEST_FRAMES  = 50;                           // Frames in the sequence
    localparam int TIMEOUT_CLKS = (TEST_FRAMES + 3) * FRAME_CLKS;

    `include "tb_frogger_ref.svh"

    logic               Clk;
    logic               reset;
    game_pkg::keycode_t keycode;
    game_pkg::seg_t     hex0, hex1;
    game_pkg::dir_t     leds;
    game_pkg::color_t   vga_r, vga_g, vga_b;
    logic               vga_hs, vga_vs, vga_blank_n, pixel_en;

    // Frog and LED model
    int             frog_x_m, frog_y_m;
    bit             hop_wait;
    game_pkg::dir_t frame_dir;          // Direction held into the next frame start
    game_pkg::dir_t led_m;
    int             frames_seen;
    int             cycle_count;
    event           frame_tick;         // Fired at each vs falling edge

    frogger_top #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) uut
    (
        .Clk, .reset, .keycode, .hex0, .hex1, .leds,
        .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs, .vga_blank_n, .pixel_en
    );

    always #4 Clk = ~Clk;               // 8 ns period

    //----------------------------------------------------------------------
    // Error reporting and compare tasks
    //----------------------------------------------------------------------

    task automatic report_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_seg(input string name, input game_pkg::seg_t got,
                             input game_pkg::seg_t exp);
        if (got !== exp)
            report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_dir(input string name, input game_pkg::dir_t got,
                             input game_pkg::dir_t exp);
        if (got !== exp)
            report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_color(input string name, input game_pkg::color_t got,
                               input game_pkg::color_t exp);
        if (got !== exp)
            report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_sync(input string name, input bit got, input bit exp);
        if (got != exp)
            report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    //----------------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------------

    // Drive one keycode, check digits and LEDs a cycle later
    task automatic apply_key(input game_pkg::keycode_t key);
        keycode = key;
        @(negedge Clk);
        if (ref_dir(key) != '0)
            led_m = ref_dir(key);       // LEDs keep last arrow
        check_seg("hex0", hex0, ref_seg(key[3:0]));
        check_seg("hex1", hex1, ref_seg(key[7:4]));
        check_dir("leds", leds, led_m);
    endtask

    // A few random codes after vs, then the key held for this frame
    task automatic play_frame(input game_pkg::keycode_t key);
        @(frame_tick);
        @(negedge Clk);
        repeat (3) apply_key(game_pkg::keycode_t'($urandom));
        apply_key(key);
        frame_dir = ref_dir(key);
    endtask

    task automatic hop(input game_pkg::keycode_t key);
        play_frame(key);
        play_frame(8'h00);              // Release
    endtask

    // One frame start of the hop FSM
    task automatic advance_frog();
        if (!hop_wait && frame_dir != '0)
        begin
            frog_x_m = step_x(frog_x_m, frame_dir, H_VISIBLE - game_pkg::FROG_SIZE);
            frog_y_m = step_y(frog_y_m, frame_dir, V_VISIBLE - game_pkg::FROG_SIZE);
            hop_wait = 1'b1;
        end
        else if (hop_wait && frame_dir == '0)
            hop_wait = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------

    initial
    begin
        Clk         = 1'b0;
        reset       = 1'b1;
        keycode     = '0;
        cycle_count = 0;
        frames_seen = 0;
        void'($urandom(32'h87ba));
        frog_x_m  = H_VISIBLE / 2 - game_pkg::FROG_SIZE / 2;   // Bottom centre
        frog_y_m  = V_VISIBLE - game_pkg::FROG_SIZE;
        hop_wait  = 1'b0;
        frame_dir = '0;
        led_m     = '0;
        repeat (8) @(negedge Clk);
        reset = 1'b0;
        check_dir("leds", leds, '0);

        play_frame(8'h00);
        hop(game_pkg::KEY_DOWN);                // Already at bottom edge
        repeat (5) hop(game_pkg::KEY_RIGHT);    // Last one clamps
        repeat (3) play_frame(game_pkg::KEY_LEFT);  // Held, one hop only
        play_frame(8'h00);
        repeat (7) hop(game_pkg::KEY_LEFT);
        repeat (6) hop(game_pkg::KEY_UP);
        repeat (2) play_frame(game_pkg::KEY_DOWN);
        play_frame(8'h04);                      // Non-arrow counts as release
        hop(game_pkg::KEY_DOWN);
        repeat (2) play_frame(8'h00);           // Show the last position

        // Worked out by hand from the sequence above
        check_count("frog_x", frog_x_m, 0);
        check_count("frog_y", frog_y_m, 16);
        if (frames_seen != TEST_FRAMES)
            report_error("The number of frames seen does not match the test sequence");
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

    //----------------------------------------------------------------------
    // Video comparison, one sample per pixel period
    //----------------------------------------------------------------------

    initial
    begin : compare_video
        int          h, v;
        int          hs_low, hs_falls, vs_low, vs_falls, vis_count;
        bit          full_line, full_frame, prev_hs, prev_vs, exp_blank_n, pe_exp;
        logic [23:0] exp_rgb;
        // Two register stages behind the counters, so start two pixels early
        h = H_TOTAL - 2;
        v = V_TOTAL - 1;
        hs_low = 0;
        hs_falls = 0;
        vs_low = 0;
        vs_falls = 0;
        vis_count = 0;
        full_line = 1'b0;
        full_frame = 1'b0;
        prev_hs = 1'b1;
        prev_vs = 1'b1;
        pe_exp = 1'b1;                  // High at the first negedge after reset
        @(negedge reset);
        forever
        begin
            @(negedge Clk);
            // Pixel enable alternates every Clk
            check_sync("pixel_en", pixel_en, pe_exp);
            pe_exp = !pe_exp;
            if (pixel_en)
            begin
                exp_blank_n = (h < H_VISIBLE) && (v < V_VISIBLE);
                check_sync("vga_hs", vga_hs, !(h >= HS_START && h < HS_START + H_SYNC));
                check_sync("vga_vs", vga_vs, !(v >= VS_START && v < VS_START + V_SYNC));
                check_sync("vga_blank_n", vga_blank_n, exp_blank_n);
                exp_rgb = exp_blank_n ? ref_color(h, v, frog_x_m, frog_y_m) : 24'h0;
                check_color("vga_r", vga_r, exp_rgb[23:16]);
                check_color("vga_g", vga_g, exp_rgb[15:8]);
                check_color("vga_b", vga_b, exp_rgb[7:0]);

                // Pulse and visible pixel counts
                if (!vga_hs) hs_low++;
                if (prev_hs && !vga_hs) hs_falls++;
                if (!vga_vs) vs_low++;
                if (vga_blank_n) vis_count++;
                if (prev_vs && !vga_vs)
                begin
                    vs_falls++;
                    frames_seen++;
                    advance_frog();         // Frame start was just before vs
                    -> frame_tick;
                end
                prev_hs = vga_hs;
                prev_vs = vga_vs;

                // Advance the expected raster position
                if (h == H_TOTAL - 1)
                begin
                    if (full_line)
                    begin
                        check_count("hs pulses per line", hs_falls, 1);
                        check_count("hs pulse width", hs_low, H_SYNC);
                    end
                    hs_low = 0;
                    hs_falls = 0;
                    full_line = 1'b1;
                    h = 0;
                    if (v == V_TOTAL - 1)
                    begin
                        if (full_frame)
                        begin
                            check_count("vs pulses per frame", vs_falls, 1);
                            check_count("vs pulse pixels", vs_low, V_SYNC * H_TOTAL);
                            check_count("visible pixels", vis_count, H_VISIBLE * V_VISIBLE);
                        end
                        vs_low = 0;
                        vs_falls = 0;
                        vis_count = 0;
                        full_frame = 1'b1;
                        v = 0;
                    end
                    else
                        v++;
                end
                else
                    h++;
            end
        end
    end

    // Run limit from the length of the frame sequence
    always @(posedge Clk)
    begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CLKS)
            report_error("Timeout: the test sequence did not finish in time");
    end

endmodule

/* project.f */
+incdir+tb
common/vga_pkg.sv
common/game_pkg.sv
verilog/key_decoder.sv
frog/frog_motion.sv
verilog/vga_timing.sv
verilog/color_mapper.sv
verilog/frogger_top.sv
tb/tb_frogger.sv

/* run.sh */
#!/bin/sh
# Build and run the frog game testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module tb_frogger \
    --Mdir obj_dir \
    -o sim_frogger

# Exit status is non-zero when the testbench stops with $fatal
./obj_dir/sim_frogger
